// ==== cache_pkg.sv ====
//================================================
// Cache geometry constants, word, line and beat
// types, and the processor opcode enum
//================================================

package cache_pkg;

  //================================================
  // Geometry
  //================================================

  // Data word and address width
  localparam int word_bits = 32;

  // Words in one cache line
  localparam int line_words = 4;

  // Byte offset bits within a line
  localparam int offset_bits = 4;

  //================================================
  // Types
  //================================================

  typedef logic [word_bits-1:0] word_t;

  // Word 0 sits in the low bits
  typedef logic [line_words*word_bits-1:0] line_t;

  // Word position within a line
  typedef logic [1:0] beat_t;

  // Every processor opcode returns the old word
  typedef enum logic [2:0] {
    op_read,
    op_write,
    op_amo_add,
    op_amo_and,
    op_amo_or
  } cache_op_e;

endpackage

// ==== ctrl_dpath_if.sv ====
//================================================
// Control and status bundle between the cache
// controller and the cache datapath
//================================================

interface ctrl_dpath_if import cache_pkg::*; ();

  // Control driven by the FSM
  logic      req_en;
  logic      tag_wen;
  logic      data_wen;
  logic      is_refill;
  logic      way_sel;
  logic      refill_word_en;
  logic      mark_dirty;
  logic      touch_lru;
  logic      evict_addr_sel;

  // Status back from the datapath
  logic      hit_0;
  logic      hit_1;
  logic      lru_way;
  logic      victim_dirty;
  cache_op_e req_op;

  modport ctrl (
    output req_en, tag_wen, data_wen, is_refill, way_sel,
    output refill_word_en, mark_dirty, touch_lru, evict_addr_sel,
    input  hit_0, hit_1, lru_way, victim_dirty, req_op
  );

  modport dpath (
    input  req_en, tag_wen, data_wen, is_refill, way_sel,
    input  refill_word_en, mark_dirty, touch_lru, evict_addr_sel,
    output hit_0, hit_1, lru_way, victim_dirty, req_op
  );

endinterface

// ==== beat_counter.sv ====
//================================================
// Memory beat counter for line eviction and refill
//================================================

module beat_counter import cache_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  beat_clear,
  input  logic  beat_step,
  output beat_t beat_idx,
  output logic  beat_last
);

  // Wraps to zero after the last word of a line
  always_ff @(posedge clk) begin
    if (reset) begin
      beat_idx <= '0;
    end else if (beat_clear) begin
      beat_idx <= '0;
    end else if (beat_step) begin
      beat_idx <= beat_idx + beat_t'(1);
    end
  end

  assign beat_last = (beat_idx == beat_t'(line_words - 1));

endmodule

// ==== cache_dpath.sv ====
//================================================
// Cache datapath with request registers, tag and
// data arrays, refill buffer, atomic unit and word select
//================================================

module cache_dpath import cache_pkg::*; #(
  parameter int nsets = 8
) (
  input  logic      clk,
  input  logic      reset,
  input  cache_op_e cache_op,
  input  word_t     cache_addr,
  input  word_t     cache_wdata,
  output word_t     cache_rdata,
  output word_t     mem_addr,
  output word_t     mem_wdata,
  input  word_t     mem_rdata,
  input  beat_t     beat_idx,
  ctrl_dpath_if.dpath cd_if
);

  localparam int idx_bits = $clog2(nsets);
  localparam int tag_bits = word_bits - offset_bits - idx_bits;

  //================================================
  // Request registers
  //================================================

  cache_op_e req_op_q;
  word_t     req_addr_q;
  word_t     req_wdata_q;

  always_ff @(posedge clk) begin
    if (cd_if.req_en) begin
      req_op_q    <= cache_op;
      req_addr_q  <= cache_addr;
      req_wdata_q <= cache_wdata;
    end
  end

  assign cd_if.req_op = req_op_q;

  // Address fields of the held request
  logic [tag_bits-1:0] req_tag;
  logic [idx_bits-1:0] req_idx;
  beat_t               req_word;

  assign req_tag  = req_addr_q[word_bits-1 -: tag_bits];
  assign req_idx  = req_addr_q[offset_bits +: idx_bits];
  assign req_word = beat_t'(req_addr_q[offset_bits-1:2]);

  //================================================
  // Line state and storage
  //================================================

  logic [tag_bits-1:0]      tag_q [2][nsets];
  line_t                    data_q [2][nsets];
  logic [1:0][nsets-1:0]    valid_q;
  logic [1:0][nsets-1:0]    dirty_q;
  logic [nsets-1:0]         lru_q;
  line_t                    refill_buf;

  line_t cur_line;
  line_t merged_line;
  word_t old_word;
  word_t amo_result;

  // Valid, dirty and LRU bits
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else begin
      if (cd_if.tag_wen) begin
        valid_q[cd_if.way_sel][req_idx] <= 1'b1;
        dirty_q[cd_if.way_sel][req_idx] <= 1'b0;
      end
      if (cd_if.mark_dirty) begin
        dirty_q[cd_if.way_sel][req_idx] <= 1'b1;
      end
      // The other way becomes least recently used
      if (cd_if.touch_lru) begin
        lru_q[req_idx] <= ~cd_if.way_sel;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cd_if.tag_wen) begin
      tag_q[cd_if.way_sel][req_idx] <= req_tag;
    end
    if (cd_if.data_wen) begin
      data_q[cd_if.way_sel][req_idx] <= cd_if.is_refill ? refill_buf : merged_line;
    end
    if (cd_if.refill_word_en) begin
      refill_buf[beat_idx*word_bits +: word_bits] <= mem_rdata;
    end
    // Old word is returned for every opcode
    if (cd_if.data_wen && !cd_if.is_refill) begin
      cache_rdata <= old_word;
    end
  end

  //================================================
  // Tag check and victim status
  //================================================

  assign cd_if.hit_0 = valid_q[0][req_idx] && (tag_q[0][req_idx] == req_tag);
  assign cd_if.hit_1 = valid_q[1][req_idx] && (tag_q[1][req_idx] == req_tag);

  assign cd_if.lru_way      = lru_q[req_idx];
  assign cd_if.victim_dirty = valid_q[cd_if.lru_way][req_idx] &&
                              dirty_q[cd_if.lru_way][req_idx];

  //================================================
  // Word select and atomic unit
  //================================================

  assign cur_line = data_q[cd_if.way_sel][req_idx];
  assign old_word = cur_line[req_word*word_bits +: word_bits];

  always_comb begin
    case (cd_if.req_op)
      op_write:   amo_result = req_wdata_q;
      op_amo_add: amo_result = old_word + req_wdata_q;
      op_amo_and: amo_result = old_word & req_wdata_q;
      op_amo_or:  amo_result = old_word | req_wdata_q;
      default:    amo_result = old_word;
    endcase
  end

  // Only the addressed word changes
  always_comb begin
    merged_line = cur_line;
    merged_line[req_word*word_bits +: word_bits] = amo_result;
  end

  //================================================
  // Memory port
  //================================================

  logic [tag_bits-1:0] mem_tag;

  // Victim tag during write-back, request tag on refill
  assign mem_tag   = cd_if.evict_addr_sel ? tag_q[cd_if.way_sel][req_idx] : req_tag;
  assign mem_addr  = {mem_tag, req_idx, beat_idx, {(offset_bits - 2){1'b0}}};
  assign mem_wdata = cur_line[beat_idx*word_bits +: word_bits];

endmodule

// ==== cache_ctrl.sv ====
//================================================
// Cache controller FSM for tag check, write-back,
// refill, update and both req/ack handshakes
//================================================

module cache_ctrl import cache_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic cache_req,
  output logic cache_ack,
  output logic mem_req,
  output logic mem_we,
  input  logic mem_ack,
  output logic beat_clear,
  output logic beat_step,
  input  logic beat_last,
  ctrl_dpath_if.ctrl cd_if
);

  typedef enum logic [3:0] {
    idle,
    tag_check,
    evict_req,
    evict_wait,
    refill_req,
    refill_wait,
    line_write,
    update,
    respond
  } cache_state_e;

  cache_state_e state_q;
  cache_state_e state_d;
  logic         way_q;
  logic         way_d;
  logic         hit;

  assign hit = cd_if.hit_0 || cd_if.hit_1;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= idle;
      way_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      way_q   <= way_d;
    end
  end

  //================================================
  // Next state
  //================================================

  always_comb begin
    state_d = state_q;
    way_d   = way_q;
    case (state_q)
      idle: begin
        if (cache_req) begin
          state_d = tag_check;
        end
      end
      tag_check: begin
        if (hit) begin
          way_d   = cd_if.hit_1;
          state_d = update;
        end else begin
          // Miss replaces the LRU way
          way_d   = cd_if.lru_way;
          state_d = cd_if.victim_dirty ? evict_req : refill_req;
        end
      end
      evict_req: begin
        if (mem_ack) begin
          state_d = evict_wait;
        end
      end
      evict_wait: begin
        if (!mem_ack) begin
          state_d = beat_last ? refill_req : evict_req;
        end
      end
      refill_req: begin
        if (mem_ack) begin
          state_d = refill_wait;
        end
      end
      refill_wait: begin
        if (!mem_ack) begin
          state_d = beat_last ? line_write : refill_req;
        end
      end
      line_write: state_d = update;
      update:     state_d = respond;
      // Hold the ack until the requester lets go
      respond: begin
        if (!cache_req) begin
          state_d = idle;
        end
      end
      default: state_d = idle;
    endcase
  end

  //================================================
  // Outputs
  //================================================

  always_comb begin
    cd_if.req_en         = (state_q == idle) && cache_req;
    cd_if.tag_wen        = (state_q == line_write);
    cd_if.data_wen       = (state_q == line_write) || (state_q == update);
    cd_if.is_refill      = (state_q == line_write);
    cd_if.way_sel        = way_q;
    cd_if.refill_word_en = (state_q == refill_req) && mem_ack;
    cd_if.mark_dirty     = (state_q == update) && (cd_if.req_op != op_read);
    cd_if.touch_lru      = (state_q == update);
    cd_if.evict_addr_sel = (state_q == evict_req);
  end

  // Beat moves on once memory has dropped its ack
  assign beat_clear = (state_q == tag_check);
  assign beat_step  = ((state_q == evict_wait) || (state_q == refill_wait)) && !mem_ack;

  assign cache_ack = (state_q == respond);
  assign mem_req   = (state_q == evict_req) || (state_q == refill_req);
  assign mem_we    = (state_q == evict_req);

endmodule

// ==== blocking_cache.sv ====
//================================================
// Two-way blocking L1 data cache top level
//================================================

module blocking_cache import cache_pkg::*; #(
  parameter int nsets = 8
) (
  input  logic      clk,
  input  logic      reset,
  // Processor side
  input  logic      cache_req,
  input  cache_op_e cache_op,
  input  word_t     cache_addr,
  input  word_t     cache_wdata,
  output logic      cache_ack,
  output word_t     cache_rdata,
  // Memory side
  output logic      mem_req,
  output logic      mem_we,
  output word_t     mem_addr,
  output word_t     mem_wdata,
  input  logic      mem_ack,
  input  word_t     mem_rdata
);

  ctrl_dpath_if cd_if ();

  logic  beat_clear;
  logic  beat_step;
  beat_t beat_idx;
  logic  beat_last;

  cache_ctrl i_cache_ctrl (
    .clk        (clk),
    .reset      (reset),
    .cache_req  (cache_req),
    .cache_ack  (cache_ack),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_ack    (mem_ack),
    .beat_clear (beat_clear),
    .beat_step  (beat_step),
    .beat_last  (beat_last),
    .cd_if      (cd_if.ctrl)
  );

  cache_dpath #(
    .nsets (nsets)
  ) i_cache_dpath (
    .clk         (clk),
    .reset       (reset),
    .cache_op    (cache_op),
    .cache_addr  (cache_addr),
    .cache_wdata (cache_wdata),
    .cache_rdata (cache_rdata),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata),
    .beat_idx    (beat_idx),
    .cd_if       (cd_if.dpath)
  );

  beat_counter i_beat_counter (
    .clk        (clk),
    .reset      (reset),
    .beat_clear (beat_clear),
    .beat_step  (beat_step),
    .beat_idx   (beat_idx),
    .beat_last  (beat_last)
  );

endmodule

// ==== tb_blocking_cache.sv ====
//================================================
// Testbench for the blocking cache with memory model,
// shadow memory, LFSR, directed tests and watchdog
//================================================

module tb_blocking_cache import cache_pkg::*;;

  localparam int directed_ops = 14;
  localparam int random_ops   = 40;
  // 60 cycles of 4 time units for each operation
  localparam int watchdog_time = (directed_ops + random_ops) * 60 * 4;

  logic      clk;
  logic      reset;
  logic      cache_req;
  cache_op_e cache_op;
  word_t     cache_addr;
  word_t     cache_wdata;
  logic      cache_ack;
  word_t     cache_rdata;
  logic      mem_req;
  logic      mem_we;
  word_t     mem_addr;
  word_t     mem_wdata;
  logic      mem_ack;
  word_t     mem_rdata;

  int    checks = 0;
  int    errors = 0;
  word_t lfsr = 32'he7f6;

  // Memory contents seen by the cache and the expected view
  word_t mem_model [word_t];
  word_t shadow [word_t];
  word_t rd_addrs [$];
  word_t wr_addrs [$];
  word_t wr_data [$];
  logic  beat_order [$];

  blocking_cache i_blocking_cache (
    .clk         (clk),
    .reset       (reset),
    .cache_req   (cache_req),
    .cache_op    (cache_op),
    .cache_addr  (cache_addr),
    .cache_wdata (cache_wdata),
    .cache_ack   (cache_ack),
    .cache_rdata (cache_rdata),
    .mem_req     (mem_req),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(watchdog_time);
    $display("timeout: the watchdog expired before all requests completed");
    $display("ERRORS FOUND");
    $finish;
  end

  //================================================
  // Memory models
  //================================================

  function automatic word_t mem_word(input word_t addr);
    if (mem_model.exists(addr)) begin
      return mem_model[addr];
    end
    return addr ^ 32'h5a5a0000;
  endfunction

  function automatic word_t shadow_word(input word_t addr);
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return addr ^ 32'h5a5a0000;
  endfunction

  function automatic void apply_to_shadow(input cache_op_e op, input word_t addr,
                                          input word_t wdata);
    word_t old;
    old = shadow_word(addr);
    case (op)
      op_write:   shadow[addr] = wdata;
      op_amo_add: shadow[addr] = old + wdata;
      op_amo_and: shadow[addr] = old & wdata;
      op_amo_or:  shadow[addr] = old | wdata;
      default:    shadow[addr] = old;
    endcase
  endfunction

  // Four-phase responder serving one word per beat
  initial begin
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever begin
      @(posedge clk);
      if (mem_req && !mem_ack) begin
        beat_order.push_back(mem_we);
        if (mem_we) begin
          mem_model[mem_addr] = mem_wdata;
          wr_addrs.push_back(mem_addr);
          wr_data.push_back(mem_wdata);
        end else begin
          rd_addrs.push_back(mem_addr);
          mem_rdata <= mem_word(mem_addr);
        end
        mem_ack <= 1'b1;
      end else if (!mem_req && mem_ack) begin
        mem_ack <= 1'b0;
      end
    end
  end

  //================================================
  // Helpers and compare tasks
  //================================================

  // Galois LFSR stepped once for each bit taken
  function automatic word_t take_bits(input int n);
    word_t v;
    int    i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic check_word(input word_t got, input word_t expected, input string name);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic check_count(input int got, input int expected, input string name);
    checks++;
    if (got != expected) begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic check_bit(input logic got, input logic expected, input string name);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic clear_beats();
    rd_addrs.delete();
    wr_addrs.delete();
    wr_data.delete();
    beat_order.delete();
  endtask

  // One full processor handshake with the old word checked against the shadow
  task automatic run_request(input cache_op_e op, input word_t addr, input word_t wdata,
                             output int lat);
    word_t expect_old;
    int    hold;
    expect_old = shadow_word(addr);
    apply_to_shadow(op, addr, wdata);
    @(posedge clk);
    cache_req   <= 1'b1;
    cache_op    <= op;
    cache_addr  <= addr;
    cache_wdata <= wdata;
    lat = 0;
    @(negedge clk);
    while (!cache_ack) begin
      @(negedge clk);
      lat++;
    end
    check_word(cache_rdata, expect_old, "cache_rdata");
    // Ack must stay up for a slow requester
    for (hold = 0; hold < 2; hold++) begin
      @(negedge clk);
      if (!cache_ack) begin
        errors++;
        $display("cache_ack fell while cache_req was still high");
      end
    end
    @(posedge clk);
    cache_req <= 1'b0;
    @(negedge clk);
    while (cache_ack) begin
      @(negedge clk);
    end
  endtask

  //================================================
  // Directed tests
  //================================================

  task automatic check_reset_state();
    @(negedge clk);
    check_bit(cache_ack, 1'b0, "cache_ack");
    check_bit(mem_req, 1'b0, "mem_req");
  endtask

  task automatic read_miss_then_hit();
    int lat;
    int i;
    clear_beats();
    run_request(op_read, 32'h0000_0104, '0, lat);
    check_count(rd_addrs.size(), 4, "read beats");
    check_count(wr_addrs.size(), 0, "write beats");
    for (i = 0; i < rd_addrs.size(); i++) begin
      check_word(rd_addrs[i], 32'h0000_0100 + i * 4, "mem_addr");
    end
    clear_beats();
    run_request(op_read, 32'h0000_010c, '0, lat);
    check_count(beat_order.size(), 0, "memory beats");
    check_count(lat, 3, "hit latency");
  endtask

  task automatic write_hit_then_read();
    int lat;
    clear_beats();
    run_request(op_write, 32'h0000_0104, 32'hcafe_f00d, lat);
    check_count(beat_order.size(), 0, "memory beats");
    run_request(op_read, 32'h0000_0104, '0, lat);
  endtask

  task automatic atomic_ops();
    int lat;
    run_request(op_amo_add, 32'h0000_0108, 32'h0000_1234, lat);
    run_request(op_read, 32'h0000_0108, '0, lat);
    run_request(op_amo_and, 32'h0000_010c, 32'hff00_ff0f, lat);
    run_request(op_read, 32'h0000_010c, '0, lat);
    run_request(op_amo_or, 32'h0000_0100, 32'h0101_0000, lat);
    run_request(op_read, 32'h0000_0100, '0, lat);
  endtask

  // Three tags in set 3 with the first one dirty
  task automatic dirty_eviction();
    int lat;
    int i;
    run_request(op_write, 32'h0000_0030, 32'h1357_9bdf, lat);
    run_request(op_read, 32'h0000_0130, '0, lat);
    clear_beats();
    run_request(op_read, 32'h0000_0230, '0, lat);
    check_count(wr_addrs.size(), 4, "write beats");
    check_count(rd_addrs.size(), 4, "read beats");
    for (i = 0; i < wr_addrs.size(); i++) begin
      check_word(wr_addrs[i], 32'h0000_0030 + i * 4, "mem_addr");
      check_word(wr_data[i], shadow_word(32'h0000_0030 + i * 4), "mem_wdata");
    end
    for (i = 0; i < rd_addrs.size(); i++) begin
      check_word(rd_addrs[i], 32'h0000_0230 + i * 4, "mem_addr");
    end
    // Write-back comes before the refill
    for (i = 0; i < beat_order.size(); i++) begin
      check_bit(beat_order[i], logic'(i < 4), "mem_we");
    end
    run_request(op_read, 32'h0000_0030, '0, lat);
  endtask

  task automatic random_sequence();
    int        n;
    int        lat;
    word_t     addr;
    word_t     pick;
    word_t     wdata;
    cache_op_e op;
    for (n = 0; n < random_ops; n++) begin
      addr  = (take_bits(2) << 7) | (take_bits(2) << 4) | (take_bits(2) << 2);
      pick  = take_bits(3) % 5;
      op    = cache_op_e'(pick[2:0]);
      wdata = take_bits(32);
      run_request(op, addr, wdata, lat);
    end
  endtask

  initial begin
    reset       = 1'b1;
    cache_req   = 1'b0;
    cache_op    = op_read;
    cache_addr  = '0;
    cache_wdata = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    check_reset_state();
    read_miss_then_hit();
    write_hit_then_read();
    atomic_ops();
    dirty_eviction();
    random_sequence();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
cache_pkg.sv
ctrl_dpath_if.sv
beat_counter.sv
cache_dpath.sv
cache_ctrl.sv
blocking_cache.sv
tb_blocking_cache.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "test   build with Verilator, run the testbench, pass on NO ERRORS in $(LOG)"
	@echo "clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing -f tb.f --top-module tb_blocking_cache -o sim_bin
	./obj_dir/sim_bin | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
